// File: mandelbrot_core.f
rtl/mandelbrot_pkg.sv
rtl/mandelbrot_alu.sv
rtl/orbit_engine.sv
rtl/point_scanner.sv
rtl/iter_counter.sv
rtl/scan_fsm.sv
rtl/mandelbrot_core.sv
dv/tb_clock.sv
dv/tb_mandelbrot.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the Mandelbrot tile engine testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mandelbrot -f mandelbrot_core.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: dv/tb_mandelbrot.sv
// Directed testbench for the Mandelbrot tile engine.
// Runs whole tiles and compares every pixel with an integer model of the orbit.

module tb_mandelbrot;
    import mandelbrot_pkg::*;

    localparam int TILE_POINTS = GRID_COLS * GRID_ROWS;
    localparam int WAIT_LIMIT  = 200;          // cycles allowed for one point or for done
    localparam int Z_MAX       = 2 ** (WIDTH - 1) - 1;
    localparam int Z_MIN       = -(2 ** (WIDTH - 1));

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic signed [WIDTH-1:0] cr_origin;
    logic signed [WIDTH-1:0] ci_origin;
    logic        [WIDTH-1:0] step;
    logic       [ITER_W-1:0] max_iter;
    logic                    pixel_valid;
    logic        [COL_W-1:0] pixel_col;
    logic        [ROW_W-1:0] pixel_row;
    logic       [ITER_W-1:0] pixel_iter;
    logic                    pixel_escaped;
    logic                    busy;
    logic                    done;
    scan_state_e             state;

    int errors;                                // wrong values and timeouts
    int checks;
    bit hung;                                  // set once the DUT stops answering
    int seed;
    int esc;

    tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

    mandelbrot_core dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .cr_origin     (cr_origin),
        .ci_origin     (ci_origin),
        .step          (step),
        .max_iter      (max_iter),
        .pixel_valid   (pixel_valid),
        .pixel_col     (pixel_col),
        .pixel_row     (pixel_row),
        .pixel_iter    (pixel_iter),
        .pixel_escaped (pixel_escaped),
        .busy          (busy),
        .done          (done),
        .state         (state)
    );

    // ############################
    // checking and reference model
    // ############################

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // the scanner adds step once per grid index and wraps like a register
    function automatic int grid_coord(input logic [WIDTH-1:0] origin,
                                      input logic [WIDTH-1:0] stp, input int index);
        logic [WIDTH-1:0] sum;
        sum = origin;
        for (int k = 0; k < index; k++) begin
            sum = sum + stp;
        end
        return int'($signed(sum));
    endfunction

    // z starts at 0, each step checks escape and overflow first, then the limit
    task automatic predict_point(input int cr, input int ci, input int limit,
                                 output int iter, output int escaped);
        int zr;
        int zi;
        int nzr;
        int nzi;
        int mag;
        bit stop;
        zr      = 0;
        zi      = 0;
        iter    = 0;
        escaped = 0;
        stop    = 1'b0;
        while (!stop) begin
            mag = zr * zr + zi * zi;                       // |z|^2 with 12 fraction bits
            nzr = ((zr * zr - zi * zi) >>> FRAC_BITS) + cr;
            nzi = ((2 * zr * zi) >>> FRAC_BITS) + ci;
            if (mag > ESCAPE_LIMIT || nzr > Z_MAX || nzr < Z_MIN || nzi > Z_MAX || nzi < Z_MIN) begin
                escaped = 1;
                stop    = 1'b1;
            end else if (iter == limit) begin
                stop = 1'b1;                               // ran out of iterations inside the set
            end else begin
                zr = nzr;
                zi = nzi;
                iter++;
            end
        end
    endtask

    // ############################
    // stimulus and waits
    // ############################

    task automatic pulse_start(input logic [WIDTH-1:0] cro, input logic [WIDTH-1:0] cio,
                               input logic [WIDTH-1:0] stp, input logic [ITER_W-1:0] mi);
        @(posedge clk);
        start     <= 1'b1;
        cr_origin <= cro;
        ci_origin <= cio;
        step      <= stp;
        max_iter  <= mi;
        @(posedge clk);
        start     <= 1'b0;                     // one cycle pulse
    endtask

    task automatic wait_for_pixel(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);                    // outputs settle after the rising edge
            seen = pixel_valid;
        end
    endtask

    task automatic wait_for_done(output bit seen, output int extra);
        seen  = 1'b0;
        extra = 0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = done;
            if (pixel_valid) begin
                extra++;                       // a pixel after the last point of the tile
            end
        end
    endtask

    // one full tile, optionally with a second start pulse after the first pixel
    task automatic run_tile(input string name, input logic [WIDTH-1:0] cro,
                            input logic [WIDTH-1:0] cio, input logic [WIDTH-1:0] stp,
                            input logic [ITER_W-1:0] mi, input bit restart,
                            output int escapes);
        int exp_iter;
        int exp_esc;
        int extra;
        bit seen;
        escapes = 0;
        if (hung) return;
        pulse_start(cro, cio, stp, mi);
        for (int p = 0; p < TILE_POINTS; p++) begin
            wait_for_pixel(seen);
            if (!seen) begin
                $display("%s: pixel %0d did not arrive within %0d cycles", name, p, WAIT_LIMIT);
                errors++;
                hung = 1'b1;
                return;
            end
            predict_point(grid_coord(cro, stp, p % GRID_COLS), grid_coord(cio, stp, p / GRID_COLS),
                          int'(mi), exp_iter, exp_esc);
            check_value({name, " col"}, pixel_col, p % GRID_COLS);
            check_value({name, " row"}, pixel_row, p / GRID_COLS);
            check_value({name, " iter"}, pixel_iter, exp_iter);
            check_value({name, " escaped"}, pixel_escaped, exp_esc);
            check_value({name, " busy"}, busy, 1);
            check_value({name, " state"}, state, EMIT);
            escapes += int'(pixel_escaped);
            if (restart && p == 0) begin
                pulse_start(cio, cro, stp, mi);    // swapped corner would show if it were taken
            end
        end
        wait_for_done(seen, extra);
        if (!seen) begin
            $display("%s: done did not arrive within %0d cycles", name, WAIT_LIMIT);
            errors++;
            hung = 1'b1;
            return;
        end
        check_value({name, " extra pixels"}, extra, 0);
        check_value({name, " state at done"}, state, DONE);
        @(negedge clk);
        check_value({name, " done after its pulse"}, done, 0);
        check_value({name, " busy after done"}, busy, 0);
        check_value({name, " state after done"}, state, IDLE);
    endtask

    // ############################
    // tests
    // ############################

    task automatic check_reset_state();
        @(negedge clk);
        check_value("state after reset", state, IDLE);
        check_value("busy after reset", busy, 0);
        check_value("pixel_valid after reset", pixel_valid, 0);
        check_value("done after reset", done, 0);
    endtask

    task automatic random_tiles();
        logic  [WIDTH-1:0] cro;
        logic  [WIDTH-1:0] cio;
        logic  [WIDTH-1:0] stp;
        logic [ITER_W-1:0] mi;
        int                escapes;
        for (int t = 0; t < 5; t++) begin
            cro = WIDTH'($random(seed));
            cio = WIDTH'($random(seed));
            stp = WIDTH'($random(seed) & 32'h1f);  // steps up to just under 0.5
            mi  = ITER_W'($random(seed));
            run_tile($sformatf("random tile %0d", t), cro, cio, stp, mi, 1'b0, escapes);
        end
    endtask

    initial begin
        seed      = 32'h5cc1_3e4f;
        errors    = 0;
        checks    = 0;
        hung      = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        cr_origin = '0;
        ci_origin = '0;
        step      = '0;
        max_iter  = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        check_reset_state();
        run_tile("reference tile", 8'h80, 8'hc0, 8'h20, 6'd20, 1'b0, esc);  // -2.0, -1.0, 0.5
        run_tile("zero limit", 8'he0, 8'he0, 8'h10, 6'd0, 1'b0, esc);
        check_value("zero limit escaped pixels", esc, 0);
        run_tile("outside the set", 8'h60, 8'h60, 8'h04, 6'd30, 1'b0, esc);  // corner at 1.5, 1.5
        check_value("outside the set escaped pixels", esc, TILE_POINTS);
        run_tile("start while busy", 8'h90, 8'hd0, 8'h18, 6'd12, 1'b1, esc);
        random_tiles();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: dv/tb_clock.sv
// Free-running clock for the testbench.
// PERIOD sets the full cycle in time units, the clock starts low.

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;           // half period high, half low

endmodule

// File: rtl/mandelbrot_core.sv
// Top level of the Mandelbrot tile engine. Connects the scan FSM, the point
// scanner, the orbit engine and the iteration counter.

module mandelbrot_core (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] cr_origin,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] ci_origin,
    input  logic        [mandelbrot_pkg::WIDTH-1:0] step,
    input  logic        [mandelbrot_pkg::ITER_W-1:0] max_iter,
    output logic                                    pixel_valid,
    output logic        [mandelbrot_pkg::COL_W-1:0] pixel_col,
    output logic        [mandelbrot_pkg::ROW_W-1:0] pixel_row,
    output logic        [mandelbrot_pkg::ITER_W-1:0] pixel_iter,
    output logic                                    pixel_escaped,
    output logic                                    busy,
    output logic                                    done,
    output mandelbrot_pkg::scan_state_e             state
);
    import mandelbrot_pkg::*;

    logic signed [WIDTH-1:0] cr;               // c of the point being iterated
    logic signed [WIDTH-1:0] ci;
    logic                    last_point;
    logic                    stop_escape;
    logic                    at_limit;
    logic                    scan_load;
    logic                    scan_advance;
    logic                    orbit_clear;
    logic                    orbit_update;
    logic                    iter_clear;
    logic                    iter_inc;

    // ############################
    // control
    // ############################

    scan_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .stop_escape   (stop_escape),
        .at_limit      (at_limit),
        .last_point    (last_point),
        .scan_load     (scan_load),
        .scan_advance  (scan_advance),
        .orbit_clear   (orbit_clear),
        .orbit_update  (orbit_update),
        .iter_clear    (iter_clear),
        .iter_inc      (iter_inc),
        .pixel_valid   (pixel_valid),
        .pixel_escaped (pixel_escaped),
        .busy          (busy),
        .done          (done),
        .state         (state)
    );

    // ############################
    // datapath
    // ############################

    point_scanner u_scanner (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (scan_load),
        .advance    (scan_advance),
        .cr_origin  (cr_origin),
        .ci_origin  (ci_origin),
        .step       (step),
        .cr         (cr),
        .ci         (ci),
        .col        (pixel_col),               // indices are stable through EMIT
        .row        (pixel_row),
        .last_point (last_point)
    );

    orbit_engine u_orbit (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (orbit_clear),
        .update      (orbit_update),
        .cr          (cr),
        .ci          (ci),
        .zr          (),                       // z itself is not part of the pixel result
        .zi          (),
        .stop_escape (stop_escape)
    );

    iter_counter u_iter (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (iter_clear),
        .inc      (iter_inc),
        .max_iter (max_iter),
        .count    (pixel_iter),                // count is held while the pixel is emitted
        .at_limit (at_limit)
    );

endmodule

// File: rtl/scan_fsm.sv
// Sequences one tile: INIT per point, ITERATE until a stop condition, EMIT
// the pixel, and DONE after the last point. Strobes are decoded from the state.

module scan_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        stop_escape,
    input  logic                        at_limit,
    input  logic                        last_point,
    output logic                        scan_load,
    output logic                        scan_advance,
    output logic                        orbit_clear,
    output logic                        orbit_update,
    output logic                        iter_clear,
    output logic                        iter_inc,
    output logic                        pixel_valid,
    output logic                        pixel_escaped,
    output logic                        busy,
    output logic                        done,
    output mandelbrot_pkg::scan_state_e state
);
    import mandelbrot_pkg::*;

    scan_state_e state_next;
    logic        point_stop;                   // orbit ends this cycle, either way
    logic        escaped_q;                    // reason the last orbit ended

    assign point_stop = stop_escape || at_limit;

    // ############################
    // state register
    // ############################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            escaped_q <= 1'b0;
        end else begin
            state <= state_next;
            if ((state == ITERATE) && point_stop) begin
                escaped_q <= stop_escape;      // escape wins over the limit
            end
        end
    end

    // ############################
    // next state
    // ############################

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = INIT;         // start only counts here
                end
            end
            INIT: begin
                state_next = ITERATE;
            end
            ITERATE: begin
                if (point_stop) begin
                    state_next = EMIT;         // otherwise keep stepping z
                end
            end
            EMIT: begin
                state_next = last_point ? DONE : INIT;
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;             // recover from an unused encoding
            end
        endcase
    end

    // ############################
    // decoded outputs
    // ############################

    assign scan_load    = (state == IDLE) && start;    // latch inputs with the start pulse
    assign orbit_clear  = (state == INIT);
    assign iter_clear   = (state == INIT);
    assign orbit_update = (state == ITERATE) && !point_stop;
    assign iter_inc     = (state == ITERATE) && !point_stop;   // count tracks the z updates
    assign pixel_valid  = (state == EMIT);
    assign scan_advance = (state == EMIT);     // move on while the pixel is presented
    assign pixel_escaped = escaped_q;
    assign done         = (state == DONE);
    assign busy         = (state != IDLE);

endmodule

// File: rtl/iter_counter.sv
// Counts iterations of the current point and flags the iteration limit.
// The limit is captured on clear so it stays fixed for the whole point.

module iter_counter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                clear,
    input  logic                                inc,
    input  logic [mandelbrot_pkg::ITER_W-1:0]   max_iter,
    output logic [mandelbrot_pkg::ITER_W-1:0]   count,
    output logic                                at_limit
);
    import mandelbrot_pkg::*;

    logic [ITER_W-1:0] limit_q;                // limit in force for this point

    assign at_limit = (count == limit_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= '0;
            limit_q <= '0;                     // count == limit right after reset
        end else if (clear) begin
            count   <= '0;
            limit_q <= max_iter;               // later changes on max_iter wait for the next point
        end else if (inc && !at_limit) begin
            count <= count + 1'b1;             // saturates at the limit
        end
    end

endmodule

// File: rtl/point_scanner.sv
// Walks the tile in row-major order and supplies c for the current point.
// load captures corner and step, advance moves to the next grid point.

module point_scanner (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    load,
    input  logic                                    advance,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] cr_origin,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] ci_origin,
    input  logic        [mandelbrot_pkg::WIDTH-1:0] step,
    output logic signed [mandelbrot_pkg::WIDTH-1:0] cr,
    output logic signed [mandelbrot_pkg::WIDTH-1:0] ci,
    output logic        [mandelbrot_pkg::COL_W-1:0] col,
    output logic        [mandelbrot_pkg::ROW_W-1:0] row,
    output logic                                    last_point
);
    import mandelbrot_pkg::*;

    logic signed [WIDTH-1:0] cr_base;          // real part at column 0, restored per row
    logic        [WIDTH-1:0] step_q;           // grid spacing for both axes
    logic                    row_end;          // current point is the final column

    assign row_end    = (col == COL_W'(GRID_COLS - 1));
    assign last_point = row_end && (row == ROW_W'(GRID_ROWS - 1));

    // ############################
    // grid indices
    // ############################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (load) begin
            col <= '0;                         // new tile starts at the corner
            row <= '0;
        end else if (advance) begin
            if (row_end) begin
                col <= '0;
                row <= row + 1'b1;             // wraps to zero after the last row
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ############################
    // c coordinates
    // ############################

    always_ff @(posedge clk) begin
        if (load) begin
            cr_base <= cr_origin;
            step_q  <= step;
            cr      <= cr_origin;
            ci      <= ci_origin;
        end else if (advance) begin
            if (row_end) begin
                cr <= cr_base;                 // back to the left edge
                ci <= ci + step_q;             // modulo 2^WIDTH add, same bits as signed
            end else begin
                cr <= cr + step_q;
            end
        end
    end

endmodule

// File: rtl/orbit_engine.sv
// Holds the orbit point z for the current c and steps it through the ALU.
// The FSM clears z at the start of a point and updates it once per iteration.

module orbit_engine (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    clear,
    input  logic                                    update,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] cr,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] ci,
    output logic signed [mandelbrot_pkg::WIDTH-1:0] zr,
    output logic signed [mandelbrot_pkg::WIDTH-1:0] zi,
    output logic                                    stop_escape
);
    import mandelbrot_pkg::*;

    logic signed [WIDTH-1:0] next_zr;          // ALU result for the current z
    logic signed [WIDTH-1:0] next_zi;
    logic                    size;             // |z|^2 above the escape limit
    logic                    overflow;         // next z does not fit in 2.6

    // ############################
    // one Mandelbrot step
    // ############################

    mandelbrot_alu u_alu (
        .cr       (cr),
        .ci       (ci),
        .zr       (zr),
        .zi       (zi),
        .next_zr  (next_zr),
        .next_zi  (next_zi),
        .size     (size),
        .overflow (overflow)
    );

    // both flags end the orbit, the FSM does not care which one fired
    assign stop_escape = size | overflow;

    // ############################
    // z register pair
    // ############################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            zr <= '0;                          // z = 0 keeps the flags quiet after reset
            zi <= '0;
        end else if (clear) begin
            zr <= '0;                          // every orbit starts at the origin
            zi <= '0;
        end else if (update) begin
            zr <= next_zr;                     // z <= z^2 + c
            zi <= next_zi;
        end
    end

endmodule

// File: rtl/mandelbrot_alu.sv
// One combinational step of z = z^2 + c in signed 2.6 fixed point.
// Also reports escape (|z|^2 > 4) and overflow of the next z.

module mandelbrot_alu (
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] cr,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] ci,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] zr,
    input  logic signed [mandelbrot_pkg::WIDTH-1:0] zi,
    output logic signed [mandelbrot_pkg::WIDTH-1:0] next_zr,
    output logic signed [mandelbrot_pkg::WIDTH-1:0] next_zi,
    output logic                                    size,
    output logic                                    overflow
);
    import mandelbrot_pkg::*;

    logic signed [2*WIDTH-1:0] zr_sq;          // zr * zr with 2*FRAC_BITS fraction bits
    logic signed [2*WIDTH-1:0] zi_sq;          // zi * zi, never negative
    logic signed [2*WIDTH-1:0] zr_zi;          // cross product for the imaginary part

    logic signed [2*WIDTH:0]   sq_diff;        // zr^2 - zi^2, one guard bit
    logic signed [2*WIDTH:0]   cross_dbl;      // 2 * zr * zi, needs the guard bit for 2 * 2^14
    logic        [2*WIDTH:0]   sq_sum;         // |z|^2 at full precision

    logic signed [2*WIDTH:0]   wide_zr;        // next real part before truncation
    logic signed [2*WIDTH:0]   wide_zi;        // next imaginary part before truncation
    logic        [WIDTH+1:0]   zr_top;         // bits that must all match the new sign bit
    logic        [WIDTH+1:0]   zi_top;
    logic                      overflow_r;
    logic                      overflow_i;

    // ############################
    // products
    // ############################

    assign zr_sq = zr * zr;                    // both operands sign extended to 16 bits
    assign zi_sq = zi * zi;
    assign zr_zi = zr * zi;

    assign sq_diff   = zr_sq - zi_sq;          // signed context extends both to 17 bits
    assign cross_dbl = $signed({zr_zi, 1'b0}); // shift left by one keeps the sign in bit 16
    assign sq_sum    = $unsigned(zr_sq) + $unsigned(zi_sq); // squares are non-negative

    // ############################
    // next z
    // ############################

    // drop FRAC_BITS to return to 2.6, then add c at the same scale
    assign wide_zr = (sq_diff >>> FRAC_BITS) + cr;
    assign wide_zi = (cross_dbl >>> FRAC_BITS) + ci;

    assign next_zr = wide_zr[WIDTH-1:0];       // plain truncation, overflow flags the bad cases
    assign next_zi = wide_zi[WIDTH-1:0];

    // ############################
    // flags
    // ############################

    assign zr_top = wide_zr[2*WIDTH:WIDTH-1];  // sign bit of the result and everything above it
    assign zi_top = wide_zi[2*WIDTH:WIDTH-1];

    // a value fits in WIDTH bits only if these bits are all ones or all zeros
    assign overflow_r = ~((&zr_top) | ~(|zr_top));
    assign overflow_i = ~((&zi_top) | ~(|zi_top));
    assign overflow   = overflow_r | overflow_i;

    assign size = (sq_sum > ESCAPE_LIMIT);     // strictly greater than 4.0 escapes

endmodule

// File: rtl/mandelbrot_pkg.sv
// Shared definitions for the Mandelbrot tile engine.
// Holds the fixed-point format, the tile size and the FSM state type.

package mandelbrot_pkg;

    // ############################
    // number format
    // ############################

    localparam int WIDTH     = 8;              // every fixed-point value, signed
    localparam int FRAC_BITS = WIDTH - 2;      // 2.6 format for an 8 bit word

    // squares carry twice the fraction bits, so 4.0 becomes 4 << 12
    localparam int unsigned ESCAPE_LIMIT = 4 << (2 * FRAC_BITS);

    // ############################
    // tile and iteration sizes
    // ############################

    localparam int ITER_W    = 6;              // width of the limit and the iteration count
    localparam int GRID_COLS = 4;              // points per row
    localparam int GRID_ROWS = 4;              // rows per tile
    localparam int COL_W     = 2;              // enough for GRID_COLS - 1
    localparam int ROW_W     = 2;              // enough for GRID_ROWS - 1

    // ############################
    // scan sequencing
    // ############################

    typedef enum logic [2:0] {
        IDLE,                                  // waiting for start
        INIT,                                  // z and count go to zero
        ITERATE,                               // one ALU step per clock
        EMIT,                                  // pixel result is on the outputs
        DONE                                   // one cycle done pulse
    } scan_state_e;

endpackage
